// ==== hw/imd_pkg.sv ====
// Encodings shared by the multiply/divide unit and its testbench.
// The operation code is the 4-bit field coming out of the decoder.

package imd_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Data width
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int IMD_REG_WIDTH_DEF = 32;	// Default register width.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decoded operations
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [3:0] {
		IMD_NOP   = 4'd0,	// No HI/LO activity.
		IMD_MFHI  = 4'd1,	// Read HI.
		IMD_MFLO  = 4'd2,	// Read LO.
		IMD_MTHI  = 4'd3,	// Write HI through the pipe.
		IMD_MTLO  = 4'd4,	// Write LO through the pipe.
		IMD_MULT  = 4'd5,	// Signed multiply.
		IMD_MULTU = 4'd6,	// Unsigned multiply.
		IMD_DIV   = 4'd7,	// Signed divide.
		IMD_DIVU  = 4'd8	// Unsigned divide.
	} imd_op_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sequencer state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// IDLE doubles as the ready state, result held there.
	typedef enum logic [1:0] {
		SEQ_IDLE = 2'd0,	// Waiting for a start strobe.
		SEQ_RUN  = 2'd1,	// Iterating one bit per cycle.
		SEQ_DONE = 2'd2		// Final sign correction.
	} imd_seq_state_t;

endpackage

// ==== hw/imd_control.sv ====
`timescale 1ns/1ps
// HI/LO control. Only one sequencer runs at a time; MTHI/MTLO still in flight
// when a sequencer completes is lost. MF after MT needs two ops in between.

module imd_control #(
	parameter int REG_WIDTH = imd_pkg::IMD_REG_WIDTH_DEF
) (
	input  logic			clk,
	input  logic			nrst,
	input  imd_pkg::imd_op_t	i_imuldiv_op,		// Decoded op in execute.
	input  logic [REG_WIDTH-1:0]	i_rs_val,		// First operand.
	input  logic [REG_WIDTH-1:0]	i_rt_val,		// Second operand.
	input  logic			i_mem_stall,		// Memory stage stall.
	input  logic			i_fetch_stall,		// Fetch stage stall.
	input  logic			i_nullify_execute,	// Kill op in execute.
	input  logic			i_nullify_mem,		// Kill op in memory.
	input  logic			i_nullify_wb,		// Kill op in writeback.
	output logic			o_exec_stall,		// Result still pending.
	output logic [REG_WIDTH-1:0]	o_rd_val,		// MFHI/MFLO data.
	output logic			o_rd_valid,		// MFHI/MFLO data valid.
	output logic			o_mul_start,		// Multiplier start strobe.
	output logic			o_div_start,		// Divider start strobe.
	output logic			o_signed,		// Signed operation.
	output logic [REG_WIDTH-1:0]	o_op_a,			// Latched rs.
	output logic [REG_WIDTH-1:0]	o_op_b,			// Latched rt.
	input  logic			i_mul_ready,		// Multiplier idle.
	input  logic [2*REG_WIDTH-1:0]	i_mul_result,		// {hi, lo} product.
	input  logic			i_div_ready,		// Divider idle.
	input  logic [2*REG_WIDTH-1:0]	i_div_result		// {rem, quot}.
);

	import imd_pkg::*;

	typedef logic [REG_WIDTH-1:0] word_t;
	typedef logic [2*REG_WIDTH-1:0] pair_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stall and handshake decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic	core_stall;	// Any stall freezing the stages.
	logic	interlock_op;	// Op that must wait for the sequencers.
	logic	seq_busy;	// Either sequencer has work in flight.
	logic	accept;		// Op leaves execute at this edge.
	logic	mul_running;	// Multiply launched and not yet written.
	logic	div_running;	// Divide launched and not yet written.
	logic	mul_done;	// Multiply result ready this cycle.
	logic	div_done;	// Divide result ready this cycle.
	pair_t	hilo;		// {HI, LO}.
	word_t	hi_val;
	word_t	lo_val;

	assign hi_val = hilo[2*REG_WIDTH-1:REG_WIDTH];
	assign lo_val = hilo[REG_WIDTH-1:0];

	assign interlock_op = (i_imuldiv_op == IMD_MFHI) || (i_imuldiv_op == IMD_MFLO) ||
		(i_imuldiv_op == IMD_MULT) || (i_imuldiv_op == IMD_MULTU) ||
		(i_imuldiv_op == IMD_DIV) || (i_imuldiv_op == IMD_DIVU);

	assign seq_busy = mul_running || div_running;
	assign o_exec_stall = !i_mem_stall && !i_fetch_stall && seq_busy && interlock_op;
	assign core_stall = o_exec_stall || i_mem_stall || i_fetch_stall;
	assign accept = !core_stall && !i_nullify_execute;

	// Ready is still high while the strobe is out, so mask it.
	assign mul_done = mul_running && i_mul_ready && !o_mul_start;
	assign div_done = div_running && i_div_ready && !o_div_start;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Execute stage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic	mthi_m;		// MTHI moving into memory.
	logic	mtlo_m;		// MTLO moving into memory.
	word_t	mt_val_m;	// Value carried by the MT op.

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mthi_m <= 1'b0;
			mtlo_m <= 1'b0;
			o_rd_valid <= 1'b0;
			o_mul_start <= 1'b0;
			o_div_start <= 1'b0;
			mul_running <= 1'b0;
			div_running <= 1'b0;
		end
		else
		begin
			o_mul_start <= 1'b0;		// Strobes last one cycle.
			o_div_start <= 1'b0;
			if (mul_done)
				mul_running <= 1'b0;	// Result written this cycle.
			if (div_done)
				div_running <= 1'b0;
			if (!core_stall)
			begin
				mthi_m <= 1'b0;
				mtlo_m <= 1'b0;
				o_rd_valid <= 1'b0;	// Valid drops at the next free edge.
				if (!i_nullify_execute)
				begin
					case (i_imuldiv_op)
					IMD_MFHI, IMD_MFLO:
						o_rd_valid <= 1'b1;
					IMD_MTHI:
						mthi_m <= 1'b1;
					IMD_MTLO:
						mtlo_m <= 1'b1;
					IMD_MULT, IMD_MULTU:
					begin
						o_mul_start <= 1'b1;
						mul_running <= 1'b1;
					end
					IMD_DIV, IMD_DIVU:
					begin
						o_div_start <= 1'b1;
						div_running <= 1'b1;
					end
					default: ;
					endcase
				end
			end
		end
	end

	// Read data, operands and MT payload.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			case (i_imuldiv_op)
			IMD_MFHI:
				o_rd_val <= hi_val;
			IMD_MFLO:
				o_rd_val <= lo_val;
			IMD_MTHI, IMD_MTLO:
				mt_val_m <= i_rs_val;
			IMD_MULT, IMD_DIV:
			begin
				o_op_a <= i_rs_val;
				o_op_b <= i_rt_val;
				o_signed <= 1'b1;
			end
			IMD_MULTU, IMD_DIVU:
			begin
				o_op_a <= i_rs_val;
				o_op_b <= i_rt_val;
				o_signed <= 1'b0;
			end
			default: ;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory stage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic	mthi_w;		// MTHI in writeback.
	logic	mtlo_w;		// MTLO in writeback.
	word_t	mt_val_w;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mthi_w <= 1'b0;
			mtlo_w <= 1'b0;
		end
		else if (!core_stall)
		begin
			mthi_w <= mthi_m && !i_nullify_mem;	// Nullify drops the write.
			mtlo_w <= mtlo_m && !i_nullify_mem;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!core_stall)
			mt_val_w <= mt_val_m;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Writeback stage and HI/LO
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			hilo <= '0;
		else if (mul_done)
			hilo <= i_mul_result;		// Completion beats MT.
		else if (div_done)
			hilo <= i_div_result;
		else if (!core_stall && !i_nullify_wb)
		begin
			if (mthi_w)
				hilo[2*REG_WIDTH-1:REG_WIDTH] <= mt_val_w;
			if (mtlo_w)
				hilo[REG_WIDTH-1:0] <= mt_val_w;
		end
	end

endmodule

// ==== hw/imd_seq_mul.sv ====
`timescale 1ns/1ps
// Shift-add multiplier, one multiplier bit per cycle, ready REG_WIDTH+1 edges
// after start. Operands are sampled only at the start strobe.

module imd_seq_mul #(
	parameter int REG_WIDTH = imd_pkg::IMD_REG_WIDTH_DEF
) (
	input  logic			clk,
	input  logic			nrst,
	input  logic			i_start,	// Start strobe, only when ready.
	input  logic			i_signed,	// Two's complement operands.
	input  logic [REG_WIDTH-1:0]	i_a,		// Multiplicand.
	input  logic [REG_WIDTH-1:0]	i_b,		// Multiplier.
	output logic			o_ready,	// Idle, result valid.
	output logic [2*REG_WIDTH-1:0]	o_result	// {upper, lower} product.
);

	import imd_pkg::*;

	localparam int CNT_WIDTH = $clog2(REG_WIDTH);

	typedef logic [REG_WIDTH-1:0] word_t;
	typedef logic [2*REG_WIDTH-1:0] pair_t;
	typedef logic [CNT_WIDTH-1:0] cnt_t;

	imd_seq_state_t		state;
	cnt_t			cnt;		// Iteration counter.
	logic			neg;		// Product needs negation.
	word_t			mag_a;
	word_t			mag_b;
	word_t			mcand;		// Multiplicand magnitude.
	pair_t			prod;		// Partial product, multiplier in low half.
	logic [REG_WIDTH:0]	acc;		// Upper half plus carry.

	assign mag_a = (i_signed && i_a[REG_WIDTH-1]) ? -i_a : i_a;
	assign mag_b = (i_signed && i_b[REG_WIDTH-1]) ? -i_b : i_b;

	// Add when the multiplier bit is set.
	assign acc = {1'b0, prod[2*REG_WIDTH-1:REG_WIDTH]} + (prod[0] ? {1'b0, mcand} : '0);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state <= SEQ_IDLE;
			cnt <= '0;
			neg <= 1'b0;
		end
		else
		begin
			case (state)
			SEQ_IDLE:
				if (i_start)
				begin
					state <= SEQ_RUN;
					cnt <= '0;
					neg <= i_signed && (i_a[REG_WIDTH-1] ^ i_b[REG_WIDTH-1]);
				end
			SEQ_RUN:
			begin
				cnt <= cnt + 1'b1;
				if (cnt == cnt_t'(REG_WIDTH - 1))
					state <= SEQ_DONE;	// Last bit consumed.
			end
			SEQ_DONE:
				state <= SEQ_IDLE;
			default:
				state <= SEQ_IDLE;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Datapath
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		case (state)
		SEQ_IDLE:
			if (i_start)
			begin
				mcand <= mag_a;
				prod <= {{REG_WIDTH{1'b0}}, mag_b};
			end
		SEQ_RUN:
			prod <= {acc, prod[REG_WIDTH-1:1]};	// Shift right with carry in.
		SEQ_DONE:
			if (neg)
				prod <= ~prod + 1'b1;		// Sign fix.
		default: ;
		endcase
	end

	assign o_ready = (state == SEQ_IDLE);
	assign o_result = prod;

endmodule

// ==== hw/imd_seq_div.sv ====
`timescale 1ns/1ps
// Restoring divider, ready REG_WIDTH+2 edges after start. Quotient truncates
// toward zero; signed divide by zero gives no defined result.

module imd_seq_div #(
	parameter int REG_WIDTH = imd_pkg::IMD_REG_WIDTH_DEF
) (
	input  logic			clk,
	input  logic			nrst,
	input  logic			i_start,	// Start strobe, only when ready.
	input  logic			i_signed,	// Two's complement operands.
	input  logic [REG_WIDTH-1:0]	i_a,		// Dividend.
	input  logic [REG_WIDTH-1:0]	i_b,		// Divisor.
	output logic			o_ready,	// Idle, result valid.
	output logic [2*REG_WIDTH-1:0]	o_result	// {remainder, quotient}.
);

	import imd_pkg::*;

	localparam int CNT_WIDTH = $clog2(REG_WIDTH + 1);

	typedef logic [REG_WIDTH-1:0] word_t;
	typedef logic [CNT_WIDTH-1:0] cnt_t;

	imd_seq_state_t		state;
	cnt_t			cnt;		// Zero is the magnitude cycle.
	logic			a_neg;		// Negative dividend.
	logic			b_neg;		// Negative divisor.
	word_t			quo;		// Dividend shifting out, quotient in.
	word_t			rem;		// Partial remainder.
	word_t			dvs;		// Divisor magnitude.
	logic [REG_WIDTH:0]	trial;		// Trial subtraction.

	// Bring the next dividend bit into the remainder and subtract.
	assign trial = {rem, quo[REG_WIDTH-1]} - {1'b0, dvs};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state <= SEQ_IDLE;
			cnt <= '0;
			a_neg <= 1'b0;
			b_neg <= 1'b0;
		end
		else
		begin
			case (state)
			SEQ_IDLE:
				if (i_start)
				begin
					state <= SEQ_RUN;
					cnt <= '0;
					a_neg <= i_signed && i_a[REG_WIDTH-1];
					b_neg <= i_signed && i_b[REG_WIDTH-1];
				end
			SEQ_RUN:
			begin
				cnt <= cnt + 1'b1;
				if (cnt == cnt_t'(REG_WIDTH))
					state <= SEQ_DONE;	// All quotient bits out.
			end
			SEQ_DONE:
				state <= SEQ_IDLE;
			default:
				state <= SEQ_IDLE;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Datapath
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		case (state)
		SEQ_IDLE:
			if (i_start)
			begin
				quo <= i_a;			// Raw operands first.
				dvs <= i_b;
				rem <= '0;
			end
		SEQ_RUN:
			if (cnt == '0)
			begin
				quo <= a_neg ? -quo : quo;	// Magnitudes.
				dvs <= b_neg ? -dvs : dvs;
			end
			else if (!trial[REG_WIDTH])
			begin
				rem <= trial[REG_WIDTH-1:0];	// Subtraction fits.
				quo <= {quo[REG_WIDTH-2:0], 1'b1};
			end
			else
			begin
				rem <= {rem[REG_WIDTH-2:0], quo[REG_WIDTH-1]};	// Restore.
				quo <= {quo[REG_WIDTH-2:0], 1'b0};
			end
		SEQ_DONE:
		begin
			if (a_neg ^ b_neg)
				quo <= -quo;
			if (a_neg)
				rem <= -rem;			// Remainder follows dividend.
		end
		default: ;
		endcase
	end

	assign o_ready = (state == SEQ_IDLE);
	assign o_result = {rem, quo};

endmodule

// ==== hw/imd_top.sv ====
`timescale 1ns/1ps
// Multiply/divide unit with HI/LO for the execute side of the pipeline.
// REG_WIDTH must be even and at least 8.

module imd_top #(
	parameter int REG_WIDTH = imd_pkg::IMD_REG_WIDTH_DEF
) (
	input  logic			clk,
	input  logic			nrst,
	input  imd_pkg::imd_op_t	i_imuldiv_op,		// Decoded op.
	input  logic [REG_WIDTH-1:0]	i_rs_val,
	input  logic [REG_WIDTH-1:0]	i_rt_val,
	input  logic			i_mem_stall,
	input  logic			i_fetch_stall,
	input  logic			i_nullify_execute,
	input  logic			i_nullify_mem,
	input  logic			i_nullify_wb,
	output logic			o_exec_stall,		// Interlock to the core.
	output logic [REG_WIDTH-1:0]	o_rd_val,
	output logic			o_rd_valid
);

	logic				mul_start;	// Control to multiplier.
	logic				div_start;	// Control to divider.
	logic				op_signed;
	logic [REG_WIDTH-1:0]		op_a;
	logic [REG_WIDTH-1:0]		op_b;
	logic				mul_ready;
	logic				div_ready;
	logic [2*REG_WIDTH-1:0]		mul_result;
	logic [2*REG_WIDTH-1:0]		div_result;

	imd_control #(
		.REG_WIDTH(REG_WIDTH)
	) u_control (
		.clk(clk),
		.nrst(nrst),
		.i_imuldiv_op(i_imuldiv_op),
		.i_rs_val(i_rs_val),
		.i_rt_val(i_rt_val),
		.i_mem_stall(i_mem_stall),
		.i_fetch_stall(i_fetch_stall),
		.i_nullify_execute(i_nullify_execute),
		.i_nullify_mem(i_nullify_mem),
		.i_nullify_wb(i_nullify_wb),
		.o_exec_stall(o_exec_stall),
		.o_rd_val(o_rd_val),
		.o_rd_valid(o_rd_valid),
		.o_mul_start(mul_start),
		.o_div_start(div_start),
		.o_signed(op_signed),
		.o_op_a(op_a),
		.o_op_b(op_b),
		.i_mul_ready(mul_ready),
		.i_mul_result(mul_result),
		.i_div_ready(div_ready),
		.i_div_result(div_result)
	);

	imd_seq_mul #(
		.REG_WIDTH(REG_WIDTH)
	) u_seq_mul (
		.clk(clk),
		.nrst(nrst),
		.i_start(mul_start),
		.i_signed(op_signed),
		.i_a(op_a),
		.i_b(op_b),
		.o_ready(mul_ready),
		.o_result(mul_result)
	);

	imd_seq_div #(
		.REG_WIDTH(REG_WIDTH)
	) u_seq_div (
		.clk(clk),
		.nrst(nrst),
		.i_start(div_start),
		.i_signed(op_signed),
		.i_a(op_a),
		.i_b(op_b),
		.o_ready(div_ready),
		.o_result(div_result)
	);

endmodule

// ==== verification/imd_properties.sv ====
`timescale 1ns/1ps
// Assertions bound into imd_control. Sampled on the rising edge, off during reset.

module imd_properties (
	input  logic			clk,
	input  logic			nrst,
	input  imd_pkg::imd_op_t	i_imuldiv_op,
	input  logic			i_mem_stall,
	input  logic			i_fetch_stall,
	input  logic			i_core_stall,	// Any stall at this edge.
	input  logic			i_accept,	// Op leaves execute.
	input  logic			i_exec_stall,
	input  logic			i_rd_valid,
	input  logic			i_mul_start,
	input  logic			i_div_start,
	input  logic			i_mul_ready,
	input  logic			i_div_ready
);

	import imd_pkg::*;

	logic	mf_accept;	// New read starts a fresh valid pulse.

	assign mf_accept = i_accept && ((i_imuldiv_op == IMD_MFHI) || (i_imuldiv_op == IMD_MFLO));

	mul_start_idle: assert property (@(posedge clk) disable iff (!nrst)
		i_mul_start |-> i_mul_ready)
		else $error("Multiplier started while busy.");

	div_start_idle: assert property (@(posedge clk) disable iff (!nrst)
		i_div_start |-> i_div_ready)
		else $error("Divider started while busy.");

	rd_valid_once: assert property (@(posedge clk) disable iff (!nrst)
		i_rd_valid && !i_core_stall && !mf_accept |=> !i_rd_valid)
		else $error("o_rd_valid held past an unstalled edge.");

	stall_yields: assert property (@(posedge clk) disable iff (!nrst)
		(i_mem_stall || i_fetch_stall) |-> !i_exec_stall)
		else $error("o_exec_stall high during a memory or fetch stall.");

endmodule

bind imd_control imd_properties u_imd_properties (
	.clk(clk),
	.nrst(nrst),
	.i_imuldiv_op(i_imuldiv_op),
	.i_mem_stall(i_mem_stall),
	.i_fetch_stall(i_fetch_stall),
	.i_core_stall(core_stall),
	.i_accept(accept),
	.i_exec_stall(o_exec_stall),
	.i_rd_valid(o_rd_valid),
	.i_mul_start(o_mul_start),
	.i_div_start(o_div_start),
	.i_mul_ready(i_mul_ready),
	.i_div_ready(i_div_ready)
);

// ==== verification/imd_tb.sv ====
`timescale 1ns/1ps
// Self-checking testbench for imd_top at 32 bits. The HI/LO model moves when an op
// is accepted, so every MTHI/MTLO is followed by two NOPs before any MFHI/MFLO.

module imd_tb;

	import imd_pkg::*;

	localparam int WIDTH = 32;	// Model uses 64-bit products.

	typedef logic [WIDTH-1:0] word_t;

	logic		clk;
	logic		nrst;
	imd_op_t	op_in;
	word_t		rs_in;
	word_t		rt_in;
	logic		mem_stall;
	logic		fetch_stall;
	logic		null_ex;
	logic		null_mem;
	logic		null_wb;
	logic		exec_stall;
	word_t		rd_val;
	logic		rd_valid;

	word_t		hi_m;		// HI model.
	word_t		lo_m;		// LO model.
	word_t		exp_q[$];	// Expected MFHI/MFLO data, in order.
	logic		stall_en;	// Random memory and fetch stalls.
	logic		rd_seen;	// Current valid pulse already compared.

	imd_top #(
		.REG_WIDTH(WIDTH)
	) u_imd_top (
		.clk(clk),
		.nrst(nrst),
		.i_imuldiv_op(op_in),
		.i_rs_val(rs_in),
		.i_rt_val(rt_in),
		.i_mem_stall(mem_stall),
		.i_fetch_stall(fetch_stall),
		.i_nullify_execute(null_ex),
		.i_nullify_mem(null_mem),
		.i_nullify_wb(null_wb),
		.o_exec_stall(exec_stall),
		.o_rd_val(rd_val),
		.o_rd_valid(rd_valid)
	);

	always #20 clk = ~clk;		// 40 ns period.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model and checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Applies one accepted op to the model, returns the read data for MF.
	function automatic word_t ref_exec(input imd_op_t op, input word_t rs, input word_t rt);
		longint			sa;
		longint			sb;
		longint			ps;
		longint unsigned	pu;
		word_t			rd;
		sa = longint'(signed'(rs));
		sb = longint'(signed'(rt));
		rd = '0;
		case (op)
		IMD_MFHI: rd = hi_m;
		IMD_MFLO: rd = lo_m;
		IMD_MTHI: hi_m = rs;
		IMD_MTLO: lo_m = rs;
		IMD_MULT:
		begin
			ps = sa * sb;
			hi_m = word_t'(ps >>> WIDTH);
			lo_m = word_t'(ps);
		end
		IMD_MULTU:
		begin
			pu = 64'(rs) * 64'(rt);
			hi_m = word_t'(pu >> WIDTH);
			lo_m = word_t'(pu);
		end
		IMD_DIV:
			if (sb != 0)
			begin
				lo_m = word_t'(sa / sb);	// Truncates toward zero.
				hi_m = word_t'(sa % sb);	// Sign of the dividend.
			end
		IMD_DIVU:
		begin
			lo_m = (rt == '0) ? '1 : rs / rt;
			hi_m = (rt == '0) ? rs : rs % rt;
		end
		default: ;
		endcase
		return rd;
	endfunction

	task automatic check_equal(input word_t got, input word_t exp, input string what);
		if (got !== exp)
		begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "Output does not match the expected value");
		end
	endtask

	// A valid pulse ends at the next edge without a core stall.
	always @(negedge clk)
	begin
		#2;
		if (nrst && rd_valid && !rd_seen)
		begin
			if (exp_q.size() == 0)
			begin
				$display("STATUS: FAIL");
				$fatal(1, "o_rd_valid rose with no MFHI or MFLO outstanding");
			end
			else
			begin
				check_equal(rd_val, exp_q.pop_front(), "o_rd_val");
				rd_seen = 1'b1;
			end
		end
		if (!(exec_stall || mem_stall || fetch_stall))
			rd_seen = 1'b0;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Holds the op until it is accepted. upd low keeps it out of the model.
	task automatic issue_op(input imd_op_t op, input word_t rs, input word_t rt,
		input logic nex, input logic nmem, input logic nwb, input logic upd);
		int	waited;
		logic	accepted;
		word_t	rd;
		waited = 0;
		accepted = 1'b0;
		while (!accepted)
		begin
			@(negedge clk);
			op_in = op;
			rs_in = rs;
			rt_in = rt;
			null_ex = nex;
			null_mem = nmem;
			null_wb = nwb;
			mem_stall = stall_en && ($urandom % 6 == 0);
			fetch_stall = stall_en && ($urandom % 6 == 0);
			#1;
			if (op == IMD_NOP || op == IMD_MTHI || op == IMD_MTLO)
				check_equal(word_t'(exec_stall), '0, "o_exec_stall");	// Never interlocked.
			accepted = !(exec_stall || mem_stall || fetch_stall);
			waited++;
			if (!accepted && waited > 200)
			begin
				$display("STATUS: FAIL");
				$fatal(1, "Timed out waiting for o_exec_stall to fall on op %s", op.name());
			end
		end
		if (!nex && upd)
		begin
			rd = ref_exec(op, rs, rt);
			if (op == IMD_MFHI || op == IMD_MFLO)
				exp_q.push_back(rd);
		end
	endtask

	task automatic issue(input imd_op_t op, input word_t rs, input word_t rt);
		issue_op(op, rs, rt, 1'b0, 1'b0, 1'b0, 1'b1);
	endtask

	function automatic word_t pick_operand();
		case ($urandom % 8)
		0: return 32'h8000_0000;	// Most negative.
		1: return '1;
		2: return '0;
		default: return $urandom;
		endcase
	endfunction

	task automatic write_hilo(input word_t hi, input word_t lo);
		issue(IMD_MTHI, hi, '0);
		issue(IMD_MTLO, lo, '0);
		issue(IMD_NOP, '0, '0);
		issue(IMD_NOP, '0, '0);
	endtask

	task automatic run_and_read(input imd_op_t op, input word_t a, input word_t b);
		issue(op, a, b);
		issue(IMD_MFLO, '0, '0);	// Interlocked until the result lands.
		issue(IMD_MFHI, '0, '0);
	endtask

	// NOPs until every expected read has been compared.
	task automatic drain();
		int	guard;
		guard = 0;
		while (exp_q.size() != 0)
		begin
			issue(IMD_NOP, '0, '0);
			guard++;
			if (guard > 100)
			begin
				$display("STATUS: FAIL");
				$fatal(1, "Timed out waiting for outstanding o_rd_valid pulses");
			end
		end
		repeat (3)
			issue(IMD_NOP, '0, '0);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial
	begin
		word_t	b;
		void'($urandom(32'h176a));
		clk = 1'b0;
		nrst = 1'b0;
		op_in = IMD_NOP;
		rs_in = '0;
		rt_in = '0;
		{mem_stall, fetch_stall} = 2'b00;
		{null_ex, null_mem, null_wb} = 3'b000;
		{hi_m, lo_m} = '0;
		stall_en = 1'b0;
		rd_seen = 1'b0;
		repeat (16) @(negedge clk);
		nrst = 1'b1;
		run_and_read(IMD_NOP, '0, '0);		// HI/LO are zero after reset.
		repeat (4)
		begin
			write_hilo($urandom, $urandom);
			issue(IMD_MFHI, '0, '0);
			issue(IMD_MFLO, '0, '0);
		end
		repeat (10)
			run_and_read(($urandom % 2) ? IMD_MULT : IMD_MULTU, pick_operand(), pick_operand());
		drain();
		for (int i = 0; i < 12; i++)
		begin
			b = pick_operand();
			run_and_read(IMD_DIV, pick_operand(), (b == '0) ? 32'd7 : b);
			b = (i % 3 == 0) ? '0 : ($urandom >> ($urandom % 32));
			run_and_read(IMD_DIVU, pick_operand(), b);
		end
		drain();
		// Killed MTLO in memory, then in writeback.
		issue_op(IMD_MTLO, $urandom, '0, 1'b0, 1'b0, 1'b0, 1'b0);
		issue_op(IMD_NOP, '0, '0, 1'b0, 1'b1, 1'b0, 1'b1);
		issue(IMD_NOP, '0, '0);
		issue(IMD_MFLO, '0, '0);
		issue_op(IMD_MTLO, $urandom, '0, 1'b0, 1'b0, 1'b0, 1'b0);
		issue(IMD_NOP, '0, '0);
		issue_op(IMD_NOP, '0, '0, 1'b0, 1'b0, 1'b1, 1'b1);
		issue(IMD_MFLO, '0, '0);
		issue_op(IMD_MFHI, '0, '0, 1'b1, 1'b0, 1'b0, 1'b1);
		drain();
		stall_en = 1'b1;
		repeat (40)
		begin
			case ($urandom % 4)
			0: write_hilo($urandom, $urandom);
			1: run_and_read(($urandom % 2) ? IMD_MULT : IMD_MULTU, $urandom, $urandom);
			2: run_and_read(IMD_DIVU, $urandom, $urandom >> ($urandom % 32));
			default: issue(($urandom % 2) ? IMD_MFHI : IMD_MFLO, '0, '0);
			endcase
		end
		stall_en = 1'b0;
		drain();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== muldiv_unit.f ====
hw/imd_pkg.sv
hw/imd_control.sv
hw/imd_seq_mul.sv
hw/imd_seq_div.sv
hw/imd_top.sv
verification/imd_properties.sv
verification/imd_tb.sv

// ==== Bender.yml ====
package:
  name: muldiv_unit

sources:
  # Synthesizable RTL, package first.
  - files:
      - hw/imd_pkg.sv
      - hw/imd_control.sv
      - hw/imd_seq_mul.sv
      - hw/imd_seq_div.sv
      - hw/imd_top.sv

  # Testbench and bound assertions.
  - target: simulation
    files:
      - verification/imd_properties.sv
      - verification/imd_tb.sv
